// File: wave_config.svh
`ifndef WAVE_CONFIG_SVH
`define WAVE_CONFIG_SVH

// ------------------------------------------------------------
// Voice count and SID cycle timing
// ------------------------------------------------------------
// Three voices share one datapath
`define NUM_VOICES     3
// Clocks per SID cycle, needs at least NUM_VOICES + 2
`define CYCLE_CLKS     8

// ------------------------------------------------------------
// Oscillator and noise generator
// ------------------------------------------------------------
`define ACC_WIDTH      24
// Noise shift register and its feedback tap
`define LFSR_WIDTH     23
`define LFSR_TAP       17
// Accumulator bit whose rising edge clocks the noise register
`define NOISE_CLK_BIT  19

`endif

// File: sid_pkg.sv
`include "wave_config.svh"

package sid_pkg;

    // Voice number, 0 to 2
    typedef logic [1:0] voice_idx_t;

    // Control register bits, sync sits at bit 0 and noise at bit 6
    typedef struct packed {
        logic noise;
        logic pulse;
        logic sawtooth;
        logic triangle;
        logic test;
        logic ring;
        logic sync;
    } control_t;

    // Full register set of one voice
    typedef struct packed {
        logic [15:0] freq;
        logic [11:0] pw;
        control_t    control;
    } voice_regs_t;

    // Oscillator state kept per voice
    typedef struct packed {
        logic [`ACC_WIDTH-1:0] acc;
    } osc_state_t;

    // Noise state kept per voice
    typedef struct packed {
        logic [`LFSR_WIDTH-1:0] lfsr;
        logic                   bit19_prev;
    } noise_state_t;

    // Sample leaving the chip, tagged with its voice
    typedef struct packed {
        voice_idx_t  voice;
        logic [11:0] wav;
    } wav_out_t;

    typedef enum logic [1:0] {
        IDLE,
        V0,
        V1,
        V2
    } seq_state_t;

endpackage

// File: cycle_timer.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module cycle_timer (
    input  logic clk,
    input  logic rst_n,
    output logic cycle_start
);

    localparam int CNT_W = $clog2(`CYCLE_CLKS);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    // Last clock of the SID cycle
    assign wrap = (cnt == CNT_W'(`CYCLE_CLKS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            cycle_start <= 1'b0;
        end else begin
            // Pulse on the first clock of the next cycle
            cycle_start <= wrap;
            cnt         <= wrap ? '0 : cnt + 1'b1;
        end
    end

endmodule

// File: voice_sequencer.sv
`timescale 1ns/1ps

module voice_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cycle_start,
    output logic                step,
    output sid_pkg::voice_idx_t voice,
    output logic                cycle_end
);
    import sid_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    // Walk V0, V1, V2 once per SID cycle
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cycle_start) begin
                    state_next = V0;
                end
            end
            V0:      state_next = V1;
            V1:      state_next = V2;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Datapath strobes decoded from the state
    always_comb begin
        step      = (state != IDLE);
        // Last voice commits the MSB rise flags
        cycle_end = (state == V2);
        case (state)
            V1:      voice = voice_idx_t'(1);
            V2:      voice = voice_idx_t'(2);
            default: voice = voice_idx_t'(0);
        endcase
    end

endmodule

// File: voice_regfile.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module voice_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [3:0]           wb_adr,
    input  logic [15:0]          wb_dat_w,
    output logic [15:0]          wb_dat_r,
    output logic                 wb_ack,
    input  sid_pkg::voice_idx_t  voice,
    output sid_pkg::voice_regs_t regs
);
    import sid_pkg::*;

    voice_regs_t regs_q [`NUM_VOICES];
    voice_idx_t  adr_voice;
    logic [1:0]  adr_field;
    logic        adr_hit;
    logic        req;
    // Ack already given, waiting for stb to drop
    logic        held;

    // ------------------------------------------------------------
    // Address decode, four slots per voice
    // ------------------------------------------------------------
    assign adr_voice = wb_adr[3:2];
    assign adr_field = wb_adr[1:0];
    // Slot 3 and voices past the last are unmapped
    assign adr_hit   = (adr_voice < `NUM_VOICES) && (adr_field != 2'd3);
    assign req       = wb_cyc && wb_stb && !held;

    // Single clock ack, one clock after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            held   <= 1'b0;
        end else begin
            wb_ack <= req;
            if (req) begin
                held <= 1'b1;
            end else if (!wb_stb) begin
                held <= 1'b0;
            end
        end
    end

    // Write lands on the same edge that raises ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VOICES; i++) begin
                regs_q[i] <= '0;
            end
        end else if (req && wb_we && adr_hit) begin
            case (adr_field)
                2'd0:    regs_q[adr_voice].freq    <= wb_dat_w;
                2'd1:    regs_q[adr_voice].pw      <= wb_dat_w[11:0];
                default: regs_q[adr_voice].control <= control_t'(wb_dat_w[6:0]);
            endcase
        end
    end

    // Read mux, unmapped slots give zero
    always_comb begin
        wb_dat_r = '0;
        if (adr_hit) begin
            case (adr_field)
                2'd0:    wb_dat_r = regs_q[adr_voice].freq;
                2'd1:    wb_dat_r = {4'b0, regs_q[adr_voice].pw};
                default: wb_dat_r = {9'b0, regs_q[adr_voice].control};
            endcase
        end
    end

    // Register set of the voice being stepped
    assign regs = regs_q[voice];

endmodule

// File: voice_store.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module voice_store #(
    parameter type      payload_t = logic [23:0],
    parameter payload_t RESET_VAL = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sid_pkg::voice_idx_t rd_voice,
    output payload_t            rd_data,
    input  logic                wr_en,
    input  payload_t            wr_data
);

    payload_t mem [`NUM_VOICES];

    // Asynchronous read of the addressed voice
    assign rd_data = mem[rd_voice];

    // Write back to the same voice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VOICES; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en) begin
            mem[rd_voice] <= wr_data;
        end
    end

endmodule

// File: phase_accumulator.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module phase_accumulator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  step,
    input  logic                  cycle_end,
    input  sid_pkg::voice_idx_t   voice,
    input  sid_pkg::voice_regs_t  regs,
    output logic [`ACC_WIDTH-1:0] acc,
    output logic                  src_msb
);
    import sid_pkg::*;

    localparam int MSB = `ACC_WIDTH - 1;

    osc_state_t             osc_rd;
    osc_state_t             osc_wr;
    voice_idx_t             src;
    logic                   synced;
    // Stored MSB per voice, feeds ring modulation
    logic [`NUM_VOICES-1:0] msb_q;
    // MSB rises collected during this SID cycle
    logic [`NUM_VOICES-1:0] rise_cur;
    // Rises of the previous SID cycle, used for sync
    logic [`NUM_VOICES-1:0] rise_prev;
    logic [`NUM_VOICES-1:0] rise_next;

    voice_store #(
        .payload_t (osc_state_t),
        .RESET_VAL (osc_state_t'('0))
    ) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_voice (voice),
        .rd_data  (osc_rd),
        .wr_en    (step),
        .wr_data  (osc_wr)
    );

    // ------------------------------------------------------------
    // Accumulate, test reset and hard sync
    // ------------------------------------------------------------
    always_comb begin
        // Source of voice v is v+2 mod 3, the previous voice
        src    = (voice == '0) ? voice_idx_t'(`NUM_VOICES - 1) : voice - 1'b1;
        synced = regs.control.sync && rise_prev[src];
        if (regs.control.test || synced) begin
            osc_wr.acc = '0;
        end else begin
            osc_wr.acc = osc_rd.acc + {{(`ACC_WIDTH - 16){1'b0}}, regs.freq};
        end
        // A reset accumulator never counts as a rise
        rise_next        = rise_cur;
        rise_next[voice] = ~osc_rd.acc[MSB] & osc_wr.acc[MSB];
        acc              = osc_wr.acc;
        src_msb          = msb_q[src];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msb_q     <= '0;
            rise_cur  <= '0;
            rise_prev <= '0;
        end else begin
            if (step) begin
                msb_q[voice] <= osc_wr.acc[MSB];
                rise_cur     <= rise_next;
            end
            // Commit includes the rise of the last voice
            if (cycle_end) begin
                rise_prev <= rise_next;
            end
        end
    end

endmodule

// File: noise_lfsr.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module noise_lfsr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                step,
    input  sid_pkg::voice_idx_t voice,
    input  logic                test,
    input  logic                acc_bit,
    output logic [7:0]          noise
);
    import sid_pkg::*;

    localparam int W = `LFSR_WIDTH;
    // Register starts full of ones
    localparam noise_state_t NOISE_RESET = '{lfsr: {W{1'b1}}, bit19_prev: 1'b0};

    noise_state_t nrd;
    noise_state_t nwr;
    logic         clk_rise;

    voice_store #(
        .payload_t (noise_state_t),
        .RESET_VAL (NOISE_RESET)
    ) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_voice (voice),
        .rd_data  (nrd),
        .wr_en    (step),
        .wr_data  (nwr)
    );

    always_comb begin
        clk_rise       = acc_bit & ~nrd.bit19_prev;
        nwr.bit19_prev = acc_bit;
        if (test) begin
            nwr.lfsr = {W{1'b1}};
        end else if (clk_rise) begin
            // Shift left, feedback from the top bit and the tap
            nwr.lfsr = {nrd.lfsr[W-2:0], nrd.lfsr[W-1] ^ nrd.lfsr[`LFSR_TAP]};
        end else begin
            nwr.lfsr = nrd.lfsr;
        end
        // Eight output taps, MSB first
        noise = {nwr.lfsr[20], nwr.lfsr[18], nwr.lfsr[14], nwr.lfsr[11],
                 nwr.lfsr[9], nwr.lfsr[5], nwr.lfsr[2], nwr.lfsr[0]};
    end

endmodule

// File: waveform_mixer.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module waveform_mixer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  step,
    input  sid_pkg::voice_idx_t   voice,
    input  sid_pkg::voice_regs_t  regs,
    input  logic [`ACC_WIDTH-1:0] acc,
    input  logic                  src_msb,
    input  logic [7:0]            noise,
    output logic                  wav_valid,
    output sid_pkg::wav_out_t     wav_out
);
    import sid_pkg::*;

    control_t    ctl;
    logic        tri_msb;
    logic        pulse_hi;
    logic [11:0] saw;
    logic [11:0] tri_wav;
    logic [11:0] pulse_wav;
    logic [11:0] noise_wav;
    logic [11:0] mix;

    // ------------------------------------------------------------
    // Waveform generation
    // ------------------------------------------------------------
    always_comb begin
        ctl       = regs.control;
        saw       = acc[`ACC_WIDTH-1 -: 12];
        // Ring swaps in the inverted source MSB
        tri_msb   = acc[`ACC_WIDTH-1] ^ (ctl.ring & ~src_msb);
        // Fold on the triangle MSB and shift left by one
        tri_wav   = {saw[10:0] ^ {11{tri_msb}}, 1'b0};
        // Test forces pulse high
        pulse_hi  = (saw >= regs.pw) || ctl.test;
        pulse_wav = {12{pulse_hi}};
        noise_wav = {noise, 4'b0};

        // Selected waveforms combine by AND
        mix = 12'hfff;
        if (ctl.triangle) begin
            mix = mix & tri_wav;
        end
        if (ctl.sawtooth) begin
            mix = mix & saw;
        end
        if (ctl.pulse) begin
            mix = mix & pulse_wav;
        end
        if (ctl.noise) begin
            mix = mix & noise_wav;
        end
        // Waveform 0 is silent
        if (!(ctl.triangle || ctl.sawtooth || ctl.pulse || ctl.noise)) begin
            mix = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wav_valid <= 1'b0;
        end else begin
            wav_valid <= step;
        end
    end

    // Sample and its voice tag
    always_ff @(posedge clk) begin
        if (step) begin
            wav_out.voice <= voice;
            wav_out.wav   <= mix;
        end
    end

endmodule

// File: sid_voice_top.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module sid_voice_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [3:0]        wb_adr,
    input  logic [15:0]       wb_dat_w,
    output logic [15:0]       wb_dat_r,
    output logic              wb_ack,
    output logic              wav_valid,
    output sid_pkg::wav_out_t wav_out
);
    import sid_pkg::*;

    logic                  cycle_start;
    logic                  step;
    logic                  cycle_end;
    voice_idx_t            voice;
    voice_regs_t           regs;
    logic [`ACC_WIDTH-1:0] acc;
    logic                  src_msb;
    logic [7:0]            noise;

    // ------------------------------------------------------------
    // Control path
    // ------------------------------------------------------------
    cycle_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cycle_start (cycle_start)
    );

    voice_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .cycle_start (cycle_start),
        .step        (step),
        .voice       (voice),
        .cycle_end   (cycle_end)
    );

    voice_regfile u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .voice    (voice),
        .regs     (regs)
    );

    // ------------------------------------------------------------
    // Shared voice datapath
    // ------------------------------------------------------------
    phase_accumulator u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .cycle_end (cycle_end),
        .voice     (voice),
        .regs      (regs),
        .acc       (acc),
        .src_msb   (src_msb)
    );

    // Noise clocked from the freshly updated accumulator
    noise_lfsr u_noise (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .voice   (voice),
        .test    (regs.control.test),
        .acc_bit (acc[`NOISE_CLK_BIT]),
        .noise   (noise)
    );

    waveform_mixer u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .voice     (voice),
        .regs      (regs),
        .acc       (acc),
        .src_msb   (src_msb),
        .noise     (noise),
        .wav_valid (wav_valid),
        .wav_out   (wav_out)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low for a few cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb_sid_voice.sv
`timescale 1ns/1ps
`include "wave_config.svh"

module tb_sid_voice;
    import sid_pkg::*;

    // Run limit of 200 SID cycles plus register traffic
    localparam int TIMEOUT_CLKS = 200 * `CYCLE_CLKS + 200;

    // Control register bits
    localparam logic [15:0] CTL_SYNC  = 16'h0001;
    localparam logic [15:0] CTL_RING  = 16'h0002;
    localparam logic [15:0] CTL_TEST  = 16'h0004;
    localparam logic [15:0] CTL_TRI   = 16'h0008;
    localparam logic [15:0] CTL_SAW   = 16'h0010;
    localparam logic [15:0] CTL_PULSE = 16'h0020;
    localparam logic [15:0] CTL_NOISE = 16'h0040;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        wav_valid;
    wav_out_t    wav_out;

    // Reference model state with one entry per voice
    logic [15:0] m_freq [`NUM_VOICES];
    logic [11:0] m_pw   [`NUM_VOICES];
    logic [6:0]  m_ctl  [`NUM_VOICES];
    logic [23:0] m_acc  [`NUM_VOICES];
    logic [22:0] m_lfsr [`NUM_VOICES];
    logic [2:0]  m_b19;
    logic [2:0]  m_rise_cur;
    logic [2:0]  m_rise_prev;

    int exp_voice;
    int sample_cnt;
    int sync_hits;
    int errors;
    int checks;
    int cycle_cnt;

    tb_clock #(.PERIOD_NS(40), .RST_CYCLES(3)) clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sid_voice_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wav_valid (wav_valid),
        .wav_out   (wav_out)
    );

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error at %0t ns: %s, expected %0h, got %0h", $time, what, expected,
                     actual);
        end
    endtask

    // ------------------------------------------------------------
    // Reference model of one voice step
    // ------------------------------------------------------------
    task automatic predict_sample(input int v, output logic [11:0] wav);
        int          src;
        logic [6:0]  c;
        logic        old_msb;
        logic        tmsb;
        logic [23:0] nacc;
        logic [22:0] l;
        logic [7:0]  nb;
        logic [11:0] saw;
        logic [11:0] tri_w;
        logic [11:0] pulse_w;
        c       = m_ctl[v];
        // Previous voice in the ring drives sync and ring
        src     = (v + 2) % 3;
        old_msb = m_acc[v][23];
        if (c[2]) begin
            nacc = '0;
        end else if (c[0] && m_rise_prev[src]) begin
            nacc = '0;
            sync_hits++;
        end else begin
            nacc = m_acc[v] + {8'h00, m_freq[v]};
        end
        m_rise_cur[v] = !old_msb && nacc[23];
        m_acc[v]      = nacc;
        // Noise shifts on a rise of accumulator bit 19
        l = m_lfsr[v];
        if (c[2]) begin
            l = '1;
        end else if (nacc[19] && !m_b19[v]) begin
            l = {l[21:0], l[22] ^ l[17]};
        end
        m_lfsr[v] = l;
        m_b19[v]  = nacc[19];
        nb        = {l[20], l[18], l[14], l[11], l[9], l[5], l[2], l[0]};
        saw       = nacc[23:12];
        tmsb      = nacc[23];
        if (c[1]) begin
            tmsb = tmsb ^ !m_acc[src][23];
        end
        // Fold the ramp down in the upper half
        if (tmsb) begin
            tri_w = {~saw[10:0], 1'b0};
        end else begin
            tri_w = {saw[10:0], 1'b0};
        end
        pulse_w = ((saw >= m_pw[v]) || c[2]) ? 12'hfff : 12'h000;
        wav = (c[6:3] == 4'b0) ? 12'h000 : 12'hfff;
        if (c[3]) wav = wav & tri_w;
        if (c[4]) wav = wav & saw;
        if (c[5]) wav = wav & pulse_w;
        if (c[6]) wav = wav & {nb, 4'h0};
        // Rise flags of the whole cycle become visible after voice 2
        if (v == 2) begin
            m_rise_prev = m_rise_cur;
        end
    endtask

    // Advance one clock and check any sample that left the DUT
    task automatic wait_clock();
        logic [11:0] expw;
        @(negedge clk);
        if (wav_valid) begin
            predict_sample(exp_voice, expw);
            check_value(exp_voice, wav_out.voice, "sample voice");
            check_value(expw, wav_out.wav, "sample value");
            exp_voice = (exp_voice + 1) % 3;
            sample_cnt++;
        end
    endtask

    task automatic track_write(input logic [3:0] adr, input logic [15:0] data);
        int v;
        v = adr[3:2];
        if (v < `NUM_VOICES) begin
            case (adr[1:0])
                2'd0:    m_freq[v] = data;
                2'd1:    m_pw[v]   = data[11:0];
                2'd2:    m_ctl[v]  = data[6:0];
                default: ;
            endcase
        end
    endtask

    task automatic wait_ack(output bit got);
        int n;
        got = 1'b0;
        for (n = 0; n < 8 && !got; n++) begin
            wait_clock();
            if (wb_ack) got = 1'b1;
        end
        if (!got) begin
            errors++;
            $display("No Wishbone ack came for the access to address %0d", wb_adr);
        end
    endtask

    // ------------------------------------------------------------
    // Wishbone master accesses
    // ------------------------------------------------------------
    task automatic wb_write(input logic [3:0] adr, input logic [15:0] data);
        bit got;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack(got);
        // Write landed on the ack edge after that edge's step
        if (got) track_write(adr, data);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wait_clock();
        // Ack lasts a single clock
        check_value(32'd0, wb_ack, "write ack length");
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [15:0] data);
        bit got;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(got);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wait_clock();
        check_value(32'd0, wb_ack, "read ack length");
    endtask

    task automatic collect_samples(input int per_voice);
        int target;
        target = sample_cnt + 3 * per_voice;
        while (sample_cnt < target) begin
            wait_clock();
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic register_access();
        logic [31:0] rnd;
        logic [15:0] rd;
        logic [3:0]  base;
        int          v;
        int          i;
        logic [3:0]  unmapped [5];
        unmapped = '{4'd3, 4'd7, 4'd11, 4'd12, 4'd15};
        for (v = 0; v < `NUM_VOICES; v++) begin
            rnd  = $urandom();
            base = {v[1:0], 2'b00};
            // Upper bits of pw and control are dropped
            wb_write(base, rnd[15:0]);
            wb_write(base + 4'd1, {4'hf, rnd[27:16]});
            wb_write(base + 4'd2, {9'h1ff, rnd[31:25]});
            wb_read(base, rd);
            check_value(rnd[15:0], rd, "freq readback");
            wb_read(base + 4'd1, rd);
            check_value({4'h0, rnd[27:16]}, rd, "pw readback");
            wb_read(base + 4'd2, rd);
            check_value({9'h000, rnd[31:25]}, rd, "control readback");
        end
        for (i = 0; i < 5; i++) begin
            wb_write(unmapped[i], 16'hbeef);
            wb_read(unmapped[i], rd);
            check_value(16'h0000, rd, "unmapped read");
        end
    endtask

    task automatic sawtooth_ramp();
        logic [31:0] rnd;
        rnd = $urandom();
        wb_write(4'd0, rnd[15:0]);
        wb_write(4'd4, rnd[31:16]);
        // Test clears the accumulators of all three voices first
        wb_write(4'd2, CTL_TEST | CTL_SAW);
        wb_write(4'd6, CTL_TEST | CTL_SAW);
        wb_write(4'd10, CTL_TEST | CTL_SAW);
        collect_samples(1);
        wb_write(4'd10, CTL_SAW);
        wb_write(4'd2, CTL_SAW);
        wb_write(4'd6, CTL_SAW);
        collect_samples(12);
    endtask

    task automatic triangle_and_pulse();
        logic [31:0] rnd;
        rnd = $urandom();
        wb_write(4'd0, rnd[15:0]);
        wb_write(4'd4, rnd[31:16]);
        rnd = $urandom();
        wb_write(4'd1, {4'h0, rnd[11:0]});
        wb_write(4'd5, {4'h0, rnd[23:12]});
        wb_write(4'd9, {4'h0, rnd[31:24], 4'h0});
        wb_write(4'd2, CTL_TRI);
        wb_write(4'd6, CTL_PULSE);
        wb_write(4'd10, CTL_TRI | CTL_PULSE);
        collect_samples(12);
        // No waveform selected
        wb_write(4'd2, 16'h0000);
        collect_samples(3);
    endtask

    task automatic test_bit_restart();
        wb_write(4'd2, CTL_TEST | CTL_SAW);
        wb_write(4'd6, CTL_TEST | CTL_PULSE);
        collect_samples(2);
        wb_write(4'd2, CTL_TEST | CTL_PULSE);
        wb_write(4'd6, CTL_TEST | CTL_SAW);
        collect_samples(2);
        // Ramps restart from zero
        wb_write(4'd2, CTL_SAW);
        wb_write(4'd6, CTL_SAW);
        collect_samples(6);
    endtask

    task automatic noise_and_ring();
        wb_write(4'd0, 16'hffff);
        wb_write(4'd4, 16'hc000);
        wb_write(4'd2, CTL_TEST | CTL_NOISE);
        wb_write(4'd6, CTL_TEST | CTL_NOISE);
        collect_samples(1);
        wb_write(4'd2, CTL_NOISE);
        wb_write(4'd6, CTL_NOISE);
        wb_write(4'd10, CTL_TRI | CTL_RING);
        collect_samples(40);
    endtask

    task automatic hard_sync();
        logic [31:0] rnd;
        int          n;
        rnd = $urandom();
        wb_write(4'd0, rnd[15:0]);
        sync_hits = 0;
        // Voice 0 follows the fast voice 2 and voice 1 follows voice 0
        wb_write(4'd2, CTL_SYNC | CTL_RING | CTL_TRI);
        wb_write(4'd6, CTL_SYNC | CTL_SAW);
        n = 0;
        while (sync_hits == 0 && n < 80) begin
            collect_samples(1);
            n++;
        end
        collect_samples(4);
        if (sync_hits == 0) begin
            errors++;
            $display("Hard sync never reset a voice because no source MSB rose in time");
        end
    endtask

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CLKS) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout, the tests did not finish within %0d clocks", TIMEOUT_CLKS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h50d));
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        exp_voice   = 0;
        sample_cnt  = 0;
        sync_hits   = 0;
        errors      = 0;
        checks      = 0;
        m_b19       = '0;
        m_rise_cur  = '0;
        m_rise_prev = '0;
        // Model starts from the reset state
        for (int v = 0; v < `NUM_VOICES; v++) begin
            m_freq[v] = '0;
            m_pw[v]   = '0;
            m_ctl[v]  = '0;
            m_acc[v]  = '0;
            m_lfsr[v] = '1;
        end
        @(posedge rst_n);
        register_access();
        // Voice 2 runs fast for the whole run and is the sync source at the end
        wb_write(4'd8, 16'hffff);
        sawtooth_ramp();
        triangle_and_pulse();
        test_bit_restart();
        noise_and_ring();
        hard_sync();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
sid_pkg.sv
cycle_timer.sv
voice_sequencer.sv
voice_regfile.sv
voice_store.sv
phase_accumulator.sv
noise_lfsr.sv
waveform_mixer.sv
sid_voice_top.sv
tb_clock.sv
tb_sid_voice.sv

// File: Bender.yml
package:
  name: sid_voice

sources:
  - include_dirs:
      - .
    files:
      - sid_pkg.sv
      - cycle_timer.sv
      - voice_sequencer.sv
      - voice_regfile.sv
      - voice_store.sv
      - phase_accumulator.sv
      - noise_lfsr.sv
      - waveform_mixer.sv
      - sid_voice_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_sid_voice.sv
